// ==== logic/cpu_settings.svh ====
// Core-wide sizes and constants, included by RTL and testbench files that need them
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define ADDR_BITS 16
`define RESET_IC 16'h0000
`define BUS_TIMEOUT 15
`define MEM_WORDS 4096
`define INOU_USER_ILLEGAL 0

`endif

// ==== logic/isa_pkg.sv ====
// Instruction word layout, opcode groups and R0 flag positions shared by decoder, execution unit and testbench
package isa_pkg;

	localparam logic [5:0] OPC_LW  = 6'o20;	// Load normal argument
	localparam logic [5:0] OPC_TW  = 6'o21;	// Read memory at N
	localparam logic [5:0] OPC_RW  = 6'o24;	// Store RA at N
	localparam logic [5:0] OPC_AW  = 6'o40;
	localparam logic [5:0] OPC_SW  = 6'o42;
	localparam logic [5:0] OPC_AWT = 6'o60;	// Add short argument
	localparam logic [5:0] OPC_LWT = 6'o65;	// Load short argument
	localparam logic [5:0] OPC_KA2 = 6'o70;	// Short jumps, A selects the kind
	localparam logic [5:0] OPC_S   = 6'o73;	// S group, only HLT here

	typedef struct packed {
		logic [5:0] opcode;
		logic       d;
		logic [2:0] a;	// Target register
		logic [2:0] b;	// B-modifier register
		logic [2:0] c;	// Argument register, 0 means next word
	} norm_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic       d;	// Negate T
		logic [2:0] a;
		logic [5:0] t;	// Short argument magnitude
	} short_fmt_t;

	typedef union packed {
		norm_fmt_t na;	// Normal-argument view
		short_fmt_t sa;	// Short-argument view
	} instr_word_t;

	typedef enum logic [3:0] {
		OP_LW, OP_TW, OP_RW, OP_AW, OP_SW, OP_AWT,
		OP_LWT, OP_UJ, OP_JZ, OP_HLT, OP_ILL
	} op_t;

	// R0 flags, bit 0 is the MSB of R0
	localparam int FLAG_Z = 0;
	localparam int FLAG_M = 1;
	localparam int FLAG_V = 2;
	localparam int FLAG_C = 3;

endpackage

// ==== logic/ctl_pkg.sv ====
// Instruction cycle states and bus requests passed between the sequencer and the Wishbone master
package ctl_pkg;

	typedef enum logic [2:0] {
		CY_FETCH,	// Instruction word read at IC
		CY_ARG,		// Decode check, optional argument word read
		CY_EXEC,	// One-cycle execute, TW adds its data read
		CY_STORE,	// RW memory write
		CY_HALT		// Stopped until reset
	} cycle_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_READ,
		BUS_WRITE
	} bus_op_t;

endpackage

// ==== logic/instr_decoder.sv ====
// Instruction register fed from the W bus and decode of its word into an opcode group and flags
`timescale 1ns/1ps

module instr_decoder import isa_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [15:0] w,			// W bus, word just read from memory
	input  logic        load_ir,	// W->IR strobe
	input  logic [0:3]  r0_flags,	// Z M V C from R0
	output instr_word_t ir,
	output op_t         op,
	output logic        c0,			// C field nonzero, argument from R[C]
	output logic        nef,		// Ineffective instruction
	output logic        xi			// Illegal instruction
);

	logic [5:0] opc;
	logic [2:0] fld_a;

	// IR register
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ir <= '0;	// Decodes as illegal, ignored until first fetch
		end else if (load_ir) begin
			ir <= w;
		end
	end

	assign opc   = ir.na.opcode;
	assign fld_a = ir.na.a;	// Same bits in both views

	// Opcode group decode
	always_comb begin
		op = OP_ILL;
		case (opc)
			OPC_LW:  op = OP_LW;
			OPC_TW:  op = OP_TW;
			OPC_RW:  op = OP_RW;
			OPC_AW:  op = OP_AW;
			OPC_SW:  op = OP_SW;
			OPC_AWT: op = OP_AWT;
			OPC_LWT: op = OP_LWT;
			OPC_KA2: begin
				if (fld_a == 3'd0) begin
					op = OP_UJ;	// Unconditional
				end else if (fld_a == 3'd2) begin
					op = OP_JZ;
				end
			end
			OPC_S: begin
				if (fld_a == 3'd0) begin
					op = OP_HLT;
				end
			end
			default: op = OP_ILL;
		endcase
	end

	// Argument form
	assign c0 = |ir.na.c;

	// Anything outside the supported set
	assign xi = (op == OP_ILL);

	// JZ falls through when Z is clear
	assign nef = (op == OP_JZ) && !r0_flags[FLAG_Z];

endmodule

// ==== logic/cycle_fsm.sv ====
// Instruction cycle sequencer driving bus requests, IR load and execution strobes
`timescale 1ns/1ps

module cycle_fsm import isa_pkg::*, ctl_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  op_t     op,
	input  logic    c0,
	input  logic    nef,
	input  logic    xi,
	input  logic    done,			// Bus transfer finished
	input  logic    timeout,		// No answer from slave
	output bus_op_t bus_op,
	output logic    bus_sel_arg,	// Address from N instead of IC
	output logic    load_ir,
	output logic    arg_load,
	output logic    exec,
	output logic    ic_step,
	output logic    halt,
	output logic    illegal,
	output logic    bus_alarm
);

	cycle_t state, state_nx;
	logic   need_arg;

	// Normal argument taken from next word
	assign need_arg = !c0 && (op inside {OP_LW, OP_TW, OP_RW, OP_AW, OP_SW});

	always_comb begin
		state_nx    = state;
		bus_op      = BUS_IDLE;
		bus_sel_arg = 1'b0;
		load_ir     = 1'b0;
		arg_load    = 1'b0;
		exec        = 1'b0;
		ic_step     = 1'b0;
		case (state)
			CY_FETCH: begin
				bus_op = BUS_READ;
				if (done) begin
					load_ir  = 1'b1;
					ic_step  = 1'b1;
					state_nx = CY_ARG;
				end
			end
			CY_ARG: begin
				// Decode valid here, IR loaded last cycle
				if (xi || op == OP_HLT) begin
					state_nx = CY_HALT;
				end else if (need_arg) begin
					bus_op = BUS_READ;	// Word at IC
					if (done) begin
						arg_load = 1'b1;
						ic_step  = 1'b1;
						state_nx = CY_EXEC;
					end
				end else begin
					state_nx = CY_EXEC;
				end
			end
			CY_EXEC: begin
				if (op == OP_TW) begin
					bus_op      = BUS_READ;
					bus_sel_arg = 1'b1;
					if (done) begin
						exec     = 1'b1;	// RA <- memory word
						state_nx = CY_FETCH;
					end
				end else if (op == OP_RW) begin
					state_nx = CY_STORE;
				end else begin
					exec     = !nef;	// Skip JZ when not taken
					state_nx = CY_FETCH;
				end
			end
			CY_STORE: begin
				bus_op      = BUS_WRITE;
				bus_sel_arg = 1'b1;
				if (done) begin
					state_nx = CY_FETCH;
				end
			end
			default: state_nx = CY_HALT;
		endcase
		if (timeout) begin
			state_nx = CY_HALT;	// Request dropped next cycle
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= CY_FETCH;
			illegal   <= 1'b0;
			bus_alarm <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == CY_ARG && xi) begin
				illegal <= 1'b1;	// Sticky until reset
			end
			if (timeout) begin
				bus_alarm <= 1'b1;
			end
		end
	end

	assign halt = (state == CY_HALT);

endmodule

// ==== logic/bus_timer.sv ====
// Watchdog on a pending bus transfer, flags a slave that never answers
`timescale 1ns/1ps
`include "cpu_settings.svh"

module bus_timer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic busy,		// Transfer in progress
	input  logic done,
	output logic timeout	// Held until busy falls
);

	localparam int CNT_W = $clog2(`BUS_TIMEOUT + 1);

	logic [CNT_W-1:0] wait_cnt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			timeout  <= 1'b0;
		end else if (!busy || done) begin
			wait_cnt <= '0;
			timeout  <= 1'b0;
		end else if (!timeout) begin
			wait_cnt <= wait_cnt + 1'b1;
			if (wait_cnt == CNT_W'(`BUS_TIMEOUT - 1)) begin
				timeout <= 1'b1;	// BUS_TIMEOUT cycles without ack
			end
		end
	end

endmodule

// ==== logic/wb_master.sv ====
// Wishbone classic master for single word reads and writes requested by the sequencer
`timescale 1ns/1ps
`include "cpu_settings.svh"

module wb_master import ctl_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  bus_op_t               bus_op,	// Held until done
	input  logic [`ADDR_BITS-1:0] addr,
	input  logic [15:0]           wdata,
	output logic [15:0]           rdata,
	output logic                  done,		// One cycle, after ack
	output logic                  busy,
	output logic                  cyc,
	output logic                  stb,
	output logic                  we,
	output logic [`ADDR_BITS-1:0] adr,
	output logic [15:0]           dat_w,
	input  logic [15:0]           dat_r,
	input  logic                  ack
);

	// Cycle control
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cyc  <= 1'b0;
			we   <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (cyc) begin
				if (ack) begin
					cyc  <= 1'b0;	// Drop in cycle after ack
					we   <= 1'b0;
					done <= 1'b1;
				end else if (bus_op == BUS_IDLE) begin
					cyc <= 1'b0;	// Request withdrawn, abort
					we  <= 1'b0;
				end
			end else if (bus_op != BUS_IDLE && !done) begin
				cyc <= 1'b1;	// Old request still visible on done
				we  <= (bus_op == BUS_WRITE);
			end
		end
	end

	// Address, write data and read capture
	always_ff @(posedge clk_sys) begin
		if (!cyc) begin
			adr   <= addr;
			dat_w <= wdata;
		end
		if (cyc && ack && !we) begin
			rdata <= dat_r;
		end
	end

	assign stb  = cyc;
	assign busy = cyc;

endmodule

// ==== logic/exec_unit.sv ====
// Registers R0-R7, instruction counter, argument forming and ALU of the core
`timescale 1ns/1ps
`include "cpu_settings.svh"

module exec_unit import isa_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  instr_word_t           ir,
	input  op_t                   op,
	input  logic [15:0]           rdata,	// Argument or TW data word
	input  logic                  arg_load,
	input  logic                  exec,
	input  logic                  ic_step,
	input  logic                  bus_sel_arg,
	output logic [`ADDR_BITS-1:0] addr,
	output logic [15:0]           wdata,
	output logic [0:3]            r0_flags
);

	logic [15:0]           regs [8];	// R0 doubles as flag word
	logic [`ADDR_BITS-1:0] ic;
	logic [15:0]           arg_word;	// Next-word argument
	logic [15:0]           ra, n_arg, t_arg;
	logic [15:0]           alu_b, alu_res;
	logic                  alu_c, alu_v;

	always_ff @(posedge clk_sys) begin
		if (arg_load) begin
			arg_word <= rdata;
		end
	end

	assign ra = regs[ir.na.a];

	// N = word or R[C], plus R[B] when B is set
	assign n_arg = ((ir.na.c == 3'd0) ? arg_word : regs[ir.na.c]) +
		((ir.na.b == 3'd0) ? 16'd0 : regs[ir.na.b]);

	// T, negated by D
	assign t_arg = ir.sa.d ? -{10'd0, ir.sa.t} : {10'd0, ir.sa.t};

	// SW as RA + ~N + 1
	always_comb begin
		case (op)
			OP_SW:   alu_b = ~n_arg;
			OP_AWT:  alu_b = t_arg;
			default: alu_b = n_arg;
		endcase
		{alu_c, alu_res} = {1'b0, ra} + {1'b0, alu_b} + 17'(op == OP_SW);
		alu_v = (ra[15] == alu_b[15]) && (alu_res[15] != ra[15]);	// Signed overflow
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ic <= `RESET_IC;
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ic_step) begin
				ic <= ic + 1'b1;	// Past instruction or argument word
			end
			if (exec) begin
				case (op)
					OP_LW:  regs[ir.na.a] <= n_arg;
					OP_TW:  regs[ir.na.a] <= rdata;
					OP_LWT: regs[ir.na.a] <= t_arg;
					OP_AW, OP_SW, OP_AWT: begin
						regs[ir.na.a] <= alu_res;
						regs[0][15 - FLAG_Z] <= (alu_res == 16'd0);	// Flags win for A=0
						regs[0][15 - FLAG_M] <= alu_res[15];
						regs[0][15 - FLAG_V] <= alu_v;
						regs[0][15 - FLAG_C] <= alu_c;
					end
					OP_UJ, OP_JZ: ic <= ic + t_arg;	// Relative to next word
					default: ;
				endcase
			end
		end
	end

	assign addr     = bus_sel_arg ? n_arg : ic;
	assign wdata    = ra;	// RW source
	assign r0_flags = regs[0][15:12];

endmodule

// ==== logic/cpu_core.sv ====
// Top level of the CPU core, joins decoder, sequencer, execution unit and Wishbone master
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core import isa_pkg::*, ctl_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	output logic                  cyc,
	output logic                  stb,
	output logic                  we,
	output logic [`ADDR_BITS-1:0] adr,
	output logic [15:0]           dat_w,
	input  logic [15:0]           dat_r,
	input  logic                  ack,
	output logic                  halt,
	output logic                  illegal,
	output logic                  bus_alarm
);

	instr_word_t           ir;
	op_t                   op;
	bus_op_t               bus_op;
	logic                  c0, nef, xi;
	logic                  load_ir, arg_load, exec, ic_step, bus_sel_arg;
	logic                  done, busy, timeout;
	logic [`ADDR_BITS-1:0] addr;
	logic [15:0]           wdata, rdata;
	logic [0:3]            r0_flags;

	instr_decoder u_dec (
		.clk_sys(clk_sys), .rst_n(rst_n), .w(rdata), .load_ir(load_ir),
		.r0_flags(r0_flags), .ir(ir), .op(op), .c0(c0), .nef(nef), .xi(xi)
	);

	cycle_fsm u_fsm (
		.clk_sys(clk_sys), .rst_n(rst_n), .op(op), .c0(c0), .nef(nef), .xi(xi),
		.done(done), .timeout(timeout), .bus_op(bus_op), .bus_sel_arg(bus_sel_arg),
		.load_ir(load_ir), .arg_load(arg_load), .exec(exec), .ic_step(ic_step),
		.halt(halt), .illegal(illegal), .bus_alarm(bus_alarm)
	);

	bus_timer u_tmr (
		.clk_sys(clk_sys), .rst_n(rst_n), .busy(busy), .done(done), .timeout(timeout)
	);

	wb_master u_wbm (
		.clk_sys(clk_sys), .rst_n(rst_n), .bus_op(bus_op), .addr(addr), .wdata(wdata),
		.rdata(rdata), .done(done), .busy(busy), .cyc(cyc), .stb(stb), .we(we),
		.adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
	);

	exec_unit u_exe (
		.clk_sys(clk_sys), .rst_n(rst_n), .ir(ir), .op(op), .rdata(rdata),
		.arg_load(arg_load), .exec(exec), .ic_step(ic_step), .bus_sel_arg(bus_sel_arg),
		.addr(addr), .wdata(wdata), .r0_flags(r0_flags)
	);

endmodule

// ==== bench/cpu_core_tb.sv ====
// Directed testbench for the CPU core, runs small programs from a Wishbone memory model and checks results
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_tb import isa_pkg::*; ();

	localparam int          N_TESTS    = 6;
	localparam int          MEM_AW     = $clog2(`MEM_WORDS);
	localparam logic [15:0] MEM_TOP    = 16'(`MEM_WORDS);	// First address without ack
	localparam int          HALT_LIMIT = 1500;
	localparam logic [2:0]  ST_HALT    = 3'b100;	// {halt, illegal, bus_alarm}
	localparam logic [2:0]  ST_ILL     = 3'b110;
	localparam logic [2:0]  ST_ALARM   = 3'b101;

	logic                  clk_sys = 1'b0;
	logic                  rst_n;
	logic                  cyc, stb, we;
	logic [`ADDR_BITS-1:0] adr;
	logic [15:0]           dat_w;
	logic [15:0]           dat_r = 16'h0000;
	logic                  ack = 1'b0;
	logic                  halt, illegal, bus_alarm;

	logic [15:0] mem [`MEM_WORDS];	// Slave memory
	logic [15:0] img [`MEM_WORDS];	// Program image, copied in during reset
	logic [15:0] pc;				// Assembly pointer
	int          errors, checks;
	int          wait_left;			// Ack delay still to go

	always #4 clk_sys = ~clk_sys;	// 8 ns

	cpu_core dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .halt(halt), .illegal(illegal),
		.bus_alarm(bus_alarm)
	);

	// Wishbone slave, driven on the falling edge
	initial begin
		void'($urandom(32'hb34c_56b6));	// Seeds the ack delays
		forever begin
			@(negedge clk_sys);
			if (!rst_n) begin
				for (int i = 0; i < `MEM_WORDS; i++) begin
					mem[i[MEM_AW-1:0]] = img[i[MEM_AW-1:0]];	// Reload program
				end
				ack <= 1'b0;
				wait_left = 0;
			end else if (cyc && stb && !ack) begin
				if (adr < MEM_TOP) begin	// Silent above memory
					if (wait_left == 0) begin
						if (we) begin
							mem[adr[MEM_AW-1:0]] = dat_w;
						end else begin
							dat_r <= mem[adr[MEM_AW-1:0]];
						end
						ack <= 1'b1;
					end else begin
						wait_left--;
					end
				end
			end else begin
				ack <= 1'b0;
				wait_left = int'($urandom % 4);	// 0 to 3 cycles for next transfer
			end
		end
	end

	function automatic logic [15:0] mem_at(input logic [15:0] a);
		return mem[a[MEM_AW-1:0]];
	endfunction

	function automatic logic [2:0] status_now();
		return {halt, illegal, bus_alarm};
	endfunction

	function automatic instr_word_t norm_word(input logic [5:0] opc, input logic [2:0] a,
		input logic [2:0] b, input logic [2:0] c);
		instr_word_t w;
		w.na.opcode = opc;
		w.na.d      = 1'b0;
		w.na.a      = a;
		w.na.b      = b;
		w.na.c      = c;	// 0 means argument in next word
		return w;
	endfunction

	function automatic instr_word_t short_word(input logic [5:0] opc, input logic d,
		input logic [2:0] a, input logic [5:0] t);
		instr_word_t w;
		w.sa.opcode = opc;
		w.sa.d      = d;
		w.sa.a      = a;
		w.sa.t      = t;
		return w;
	endfunction

	// Value of short argument, D negates
	function automatic logic [15:0] short_val(input logic d, input logic [5:0] t);
		return d ? 16'(-int'(t)) : 16'(t);
	endfunction

	// Two's-complement sum or difference with Z M V C in the top bits of R0
	task automatic alu_model(input logic [15:0] a, input logic [15:0] b, input logic sub,
		output logic [15:0] res, output logic [15:0] r0);
		int   sr;
		logic c;
		if (sub) begin
			sr = int'($signed(a)) - int'($signed(b));
			c  = (a >= b);	// No borrow
		end else begin
			sr = int'($signed(a)) + int'($signed(b));
			c  = (int'(a) + int'(b)) > 65535;
		end
		res = sr[15:0];
		r0  = {res == 16'd0, res[15], (sr > 32767) || (sr < -32768), c, 12'd0};
	endtask

	task automatic put(input logic [15:0] a, input logic [15:0] v);
		img[a[MEM_AW-1:0]] = v;
	endtask

	task automatic emit(input logic [15:0] v);
		put(pc, v);
		pc = pc + 16'd1;
	endtask

	// Normal-argument instruction with its argument word
	task automatic emit_arg(input logic [5:0] opc, input logic [2:0] a, input logic [2:0] b,
		input logic [15:0] arg);
		emit(norm_word(opc, a, b, 3'd0));
		emit(arg);
	endtask

	task automatic new_program();
		for (int i = 0; i < `MEM_WORDS; i++) begin
			img[i[MEM_AW-1:0]] = 16'(i) ^ 16'hc35a;	// Address-dependent fill
		end
		pc = 16'h0000;
	endtask

	task automatic run_program(input string name);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		rst_n <= 1'b0;
		repeat (16) @(negedge clk_sys);
		rst_n <= 1'b1;
		while (!halt && cnt < HALT_LIMIT) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (!halt) begin
			errors++;
			$display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
		end
	endtask

	task automatic compare_word(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic verify_status(input string name, input logic [2:0] exp,
		input logic [2:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s status {halt,illegal,alarm}: expected %b, actual %b",
				name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: %s", name, (errors == errs_before) ? "ok" : "errors found");
	endtask

	task automatic load_store();
		int e0;
		e0 = errors;
		new_program();
		put(16'h0300, 16'hbeef);
		emit_arg(OPC_LW, 3'd1, 3'd0, 16'h1234);
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0200);
		emit_arg(OPC_TW, 3'd2, 3'd0, 16'h0300);	// Read back from memory
		emit_arg(OPC_RW, 3'd2, 3'd0, 16'h0201);
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
		run_program("load_store");
		compare_word("load_store lw", 16'h1234, mem_at(16'h0200));
		compare_word("load_store tw", 16'hbeef, mem_at(16'h0201));
		verify_status("load_store", ST_HALT, status_now());
		report_test("load_store", e0);
	endtask

	task automatic arith_flags();
		int          e0;
		logic [15:0] xs [4];
		logic [15:0] ys [4];
		logic [15:0] res, r0;
		e0 = errors;
		xs = '{16'h7fff, 16'hffff, 16'h1234, 16'h8000};
		ys = '{16'h0001, 16'h0001, 16'h1234, 16'h0001};
		for (int k = 0; k < 4; k++) begin
			new_program();
			emit_arg(OPC_LW, 3'd1, 3'd0, xs[k]);
			emit_arg(OPC_AW, 3'd1, 3'd0, ys[k]);
			emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0250);
			emit_arg(OPC_RW, 3'd0, 3'd0, 16'h0251);	// Flag word
			emit_arg(OPC_LW, 3'd2, 3'd0, xs[k]);
			emit_arg(OPC_SW, 3'd2, 3'd0, ys[k]);
			emit_arg(OPC_RW, 3'd2, 3'd0, 16'h0252);
			emit_arg(OPC_RW, 3'd0, 3'd0, 16'h0253);
			emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
			run_program($sformatf("arith_flags %0d", k));
			alu_model(xs[k], ys[k], 1'b0, res, r0);
			compare_word($sformatf("arith_flags %0d aw", k), res, mem_at(16'h0250));
			compare_word($sformatf("arith_flags %0d aw r0", k), r0, mem_at(16'h0251));
			alu_model(xs[k], ys[k], 1'b1, res, r0);
			compare_word($sformatf("arith_flags %0d sw", k), res, mem_at(16'h0252));
			compare_word($sformatf("arith_flags %0d sw r0", k), r0, mem_at(16'h0253));
		end
		report_test("arith_flags", e0);
	endtask

	task automatic short_args();
		int e0;
		e0 = errors;
		new_program();
		emit(short_word(OPC_LWT, 1'b0, 3'd1, 6'd21));
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0210);
		emit(short_word(OPC_LWT, 1'b1, 3'd2, 6'd37));	// Negative T
		emit_arg(OPC_RW, 3'd2, 3'd0, 16'h0211);
		emit(short_word(OPC_AWT, 1'b0, 3'd2, 6'd10));
		emit_arg(OPC_RW, 3'd2, 3'd0, 16'h0212);
		emit(short_word(OPC_AWT, 1'b1, 3'd1, 6'd63));
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0213);
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
		run_program("short_args");
		compare_word("short_args lwt +", short_val(1'b0, 6'd21), mem_at(16'h0210));
		compare_word("short_args lwt -", short_val(1'b1, 6'd37), mem_at(16'h0211));
		compare_word("short_args awt +", short_val(1'b1, 6'd37) + short_val(1'b0, 6'd10),
			mem_at(16'h0212));
		compare_word("short_args awt -", short_val(1'b0, 6'd21) + short_val(1'b1, 6'd63),
			mem_at(16'h0213));
		verify_status("short_args", ST_HALT, status_now());
		report_test("short_args", e0);
	endtask

	task automatic arg_forms();
		int          e0;
		logic [15:0] base3, mod4;
		e0    = errors;
		base3 = 16'h0100;	// R3
		mod4  = 16'h0020;	// R4, B modifier
		new_program();
		emit_arg(OPC_LW, 3'd3, 3'd0, base3);
		emit_arg(OPC_LW, 3'd4, 3'd0, mod4);
		emit(norm_word(OPC_LW, 3'd1, 3'd0, 3'd3));	// N = R3
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0220);
		emit_arg(OPC_LW, 3'd2, 3'd4, 16'h0005);	// N = word + R4
		emit_arg(OPC_RW, 3'd2, 3'd0, 16'h0221);
		emit(norm_word(OPC_LW, 3'd5, 3'd4, 3'd3));	// N = R3 + R4
		emit_arg(OPC_RW, 3'd5, 3'd0, 16'h0222);
		emit_arg(OPC_RW, 3'd1, 3'd4, 16'h0203);	// Store at word + R4
		emit(norm_word(OPC_RW, 3'd2, 3'd0, 3'd3));	// Store at R3
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
		run_program("arg_forms");
		compare_word("arg_forms rc", base3, mem_at(16'h0220));
		compare_word("arg_forms word+rb", 16'h0005 + mod4, mem_at(16'h0221));
		compare_word("arg_forms rc+rb", base3 + mod4, mem_at(16'h0222));
		compare_word("arg_forms rw word+rb", base3, mem_at(16'h0203 + mod4));
		compare_word("arg_forms rw rc", 16'h0005 + mod4, mem_at(base3));
		verify_status("arg_forms", ST_HALT, status_now());
		report_test("arg_forms", e0);
	endtask

	task automatic jumps();
		int e0;
		e0 = errors;
		new_program();
		put(16'h0230, 16'h1111);	// Markers, kept when a store is skipped
		put(16'h0231, 16'h2222);
		put(16'h0232, 16'h3333);
		emit(short_word(OPC_LWT, 1'b0, 3'd1, 6'd1));	// 0
		emit(short_word(OPC_KA2, 1'b0, 3'd0, 6'd2));	// 1, UJ to 4
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0230);			// 2
		emit(short_word(OPC_LWT, 1'b0, 3'd3, 6'd0));	// 4
		emit(short_word(OPC_AWT, 1'b0, 3'd3, 6'd0));	// 5, zero result
		emit(short_word(OPC_KA2, 1'b0, 3'd2, 6'd2));	// 6, JZ to 9
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0231);			// 7
		emit(short_word(OPC_AWT, 1'b0, 3'd1, 6'd1));	// 9, nonzero result
		emit(short_word(OPC_KA2, 1'b0, 3'd2, 6'd2));	// 10, JZ falls through
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0232);			// 11
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));		// 13
		run_program("jumps");
		compare_word("jumps uj skip", 16'h1111, mem_at(16'h0230));
		compare_word("jumps jz taken", 16'h2222, mem_at(16'h0231));
		compare_word("jumps jz ineffective", short_val(1'b0, 6'd1) + short_val(1'b0, 6'd1),
			mem_at(16'h0232));
		verify_status("jumps", ST_HALT, status_now());
		report_test("jumps", e0);
	endtask

	task automatic faults();
		int e0;
		e0 = errors;
		new_program();
		put(16'h0240, 16'h4444);
		emit(short_word(OPC_LWT, 1'b0, 3'd1, 6'd7));
		emit(16'hfc00);	// Opcode 077, undefined
		emit_arg(OPC_RW, 3'd1, 3'd0, 16'h0240);
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
		run_program("faults illegal");
		verify_status("faults illegal", ST_ILL, status_now());
		compare_word("faults illegal memory", 16'h4444, mem_at(16'h0240));
		new_program();
		emit_arg(OPC_TW, 3'd1, 3'd0, 16'h8000);	// Nobody answers there
		emit(short_word(OPC_S, 1'b0, 3'd0, 6'd0));
		run_program("faults no ack");
		verify_status("faults no ack", ST_ALARM, status_now());
		report_test("faults", e0);
	endtask

	initial begin
		rst_n  = 1'b0;
		errors = 0;
		checks = 0;
		load_store();
		arith_flags();
		short_args();
		arg_forms();
		jumps();
		faults();
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (N_TESTS * 2000) @(posedge clk_sys);
		$display("Watchdog expired, the tests did not complete in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/isa_pkg.sv
logic/ctl_pkg.sv
logic/instr_decoder.sv
logic/cycle_fsm.sv
logic/bus_timer.sv
logic/wb_master.sv
logic/exec_unit.sv
logic/cpu_core.sv
bench/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the CPU core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module cpu_core_tb -Mdir obj_dir -o cpu_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/cpu_core_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
